// ==== histEqPkg.sv ====
//##########################################################
// Histogram equalizer shared definitions
// Image geometry, pixel depth and count widths used by the
// counting, CDF and remap engines and by the testbench
//##########################################################
package histEqPkg;

  // Pixel depth and number of histogram bins
  localparam int PIXEL_BITS = 8;
  localparam int BIN_COUNT = 256;

  // Image memory organisation
  localparam int WORD_BITS = 128;
  localparam int PIXELS_PER_WORD = 16;
  localparam int IMAGE_WORDS = 4;
  localparam int PIXEL_COUNT = 64;

  // Index of one pixel within the image
  localparam int PIXEL_INDEX_BITS = $clog2(PIXEL_COUNT);

  // Bin counts and CDF values, room for far larger images
  localparam int COUNT_BITS = 20;

  // Image and output memory address
  localparam int ADDR_BITS = 16;

endpackage

// ==== histCounter.sv ====
`timescale 1ns/1ps
//##########################################################
// Histogram counter
// Fetch, read and accumulate pipeline that counts every
// pixel into the bin scratchpad, forwarding counts still
// in flight so repeated pixel values never stall
//##########################################################
module histCounter (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic [histEqPkg::WORD_BITS-1:0]  imageReadData,
  output logic [histEqPkg::ADDR_BITS-1:0]  imageReadAddr,
  output logic [histEqPkg::PIXEL_BITS-1:0] binReadAddr,
  input  logic [histEqPkg::COUNT_BITS-1:0] binReadData,
  output logic                             binWrite,
  output logic [histEqPkg::PIXEL_BITS-1:0] binWriteAddr,
  output logic [histEqPkg::COUNT_BITS-1:0] binWriteData,
  output logic                             busy,
  output logic                             done
);

  import histEqPkg::*;

  // One pixel issued per cycle
  logic                        issuing;
  logic [PIXEL_INDEX_BITS-1:0] issueIdx;

  // Fetch stage
  logic                        fetchValid;
  logic                        fetchLast;
  logic [PIXEL_INDEX_BITS-1:0] fetchIdx;

  // Read stage
  logic                  readValid;
  logic                  readLast;
  logic [PIXEL_BITS-1:0] readBin;
  logic [COUNT_BITS-1:0] readCount;

  // Accumulate stage
  logic                  accValid;
  logic                  accLast;
  logic [PIXEL_BITS-1:0] accBin;
  logic [COUNT_BITS-1:0] accBase;
  logic [COUNT_BITS-1:0] accSum;

  // Write issued the cycle before
  logic                  prevValid;
  logic [PIXEL_BITS-1:0] prevBin;
  logic [COUNT_BITS-1:0] prevSum;

  // Word of the issued pixel returns one cycle later
  assign imageReadAddr = ADDR_BITS'(issueIdx / PIXELS_PER_WORD);

  // Lane select on the returned word
  assign binReadAddr = imageReadData[(fetchIdx % PIXELS_PER_WORD) * PIXEL_BITS +: PIXEL_BITS];

  // Current write beats last cycle's write
  always_comb begin
    if (accValid && accBin == readBin) begin
      readCount = accSum;
    end else if (prevValid && prevBin == readBin) begin
      readCount = prevSum;
    end else begin
      readCount = binReadData;
    end
  end

  assign accSum = accBase + COUNT_BITS'(1);

  assign binWrite = accValid;
  assign binWriteAddr = accBin;
  assign binWriteData = accSum;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      issuing <= 1'b0;
      issueIdx <= '0;
    end else begin
      if (start && !busy) begin
        busy <= 1'b1;
        issuing <= 1'b1;
        issueIdx <= '0;
      end else begin
        if (issuing) begin
          issueIdx <= issueIdx + 1'b1;
          if (issueIdx == PIXEL_INDEX_BITS'(PIXEL_COUNT - 1)) begin
            issuing <= 1'b0;
          end
        end
        // Busy drops the cycle after done
        if (done) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // Stage valids and the end marker
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      fetchValid <= 1'b0;
      fetchLast <= 1'b0;
      readValid <= 1'b0;
      readLast <= 1'b0;
      accValid <= 1'b0;
      accLast <= 1'b0;
      prevValid <= 1'b0;
      done <= 1'b0;
    end else begin
      fetchValid <= issuing;
      fetchLast <= issuing && issueIdx == PIXEL_INDEX_BITS'(PIXEL_COUNT - 1);
      readValid <= fetchValid;
      readLast <= fetchLast;
      accValid <= readValid;
      accLast <= readLast;
      prevValid <= accValid;
      done <= accLast;
    end
  end

  always_ff @(posedge clock) begin
    fetchIdx <= issueIdx;
    readBin <= binReadAddr;
    accBin <= readBin;
    accBase <= readCount;
    prevBin <= accBin;
    prevSum <= accSum;
  end

endmodule

// ==== binScratchpad.sv ====
`timescale 1ns/1ps
//##########################################################
// Bin scratchpad
// 256 count entries with valid flags, one read and one
// write port handed to whichever engine is busy, plus the
// shared image memory address
//##########################################################
module binScratchpad (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             clear,
  input  logic [histEqPkg::PIXEL_BITS-1:0] histBinReadAddr,
  input  logic                             histBinWrite,
  input  logic [histEqPkg::PIXEL_BITS-1:0] histBinWriteAddr,
  input  logic [histEqPkg::COUNT_BITS-1:0] histBinWriteData,
  input  logic [histEqPkg::PIXEL_BITS-1:0] cdfBinReadAddr,
  input  logic                             cdfBinWrite,
  input  logic [histEqPkg::PIXEL_BITS-1:0] cdfBinWriteAddr,
  input  logic [histEqPkg::COUNT_BITS-1:0] cdfBinWriteData,
  input  logic [histEqPkg::PIXEL_BITS-1:0] remapBinReadAddr,
  input  logic                             histBusy,
  input  logic                             cdfBusy,
  input  logic                             remapBusy,
  input  logic [histEqPkg::ADDR_BITS-1:0]  histReadAddr,
  input  logic [histEqPkg::ADDR_BITS-1:0]  remapReadAddr,
  output logic [histEqPkg::ADDR_BITS-1:0]  imageReadAddr,
  output logic [histEqPkg::COUNT_BITS-1:0] binReadData
);

  import histEqPkg::*;

  logic [COUNT_BITS-1:0] counts [BIN_COUNT];
  logic [BIN_COUNT-1:0]  binValid;

  // Selected port
  logic [PIXEL_BITS-1:0] readAddr;
  logic                  writeEn;
  logic [PIXEL_BITS-1:0] writeAddr;
  logic [COUNT_BITS-1:0] writeData;

  logic [COUNT_BITS-1:0] readCount;
  logic                  readHit;

  // Owner follows the busy engine, remap only reads
  always_comb begin
    readAddr = histBinReadAddr;
    writeEn = histBusy && histBinWrite;
    writeAddr = histBinWriteAddr;
    writeData = histBinWriteData;
    if (cdfBusy) begin
      readAddr = cdfBinReadAddr;
      writeEn = cdfBinWrite;
      writeAddr = cdfBinWriteAddr;
      writeData = cdfBinWriteData;
    end else if (remapBusy) begin
      readAddr = remapBinReadAddr;
      writeEn = 1'b0;
    end
  end

  assign imageReadAddr = remapBusy ? remapReadAddr : histReadAddr;

  // Read before write on a shared bin
  always_ff @(posedge clock) begin
    if (writeEn) begin
      counts[writeAddr] <= writeData;
    end
    readCount <= counts[readAddr];
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      binValid <= '0;
      readHit <= 1'b0;
    end else begin
      readHit <= binValid[readAddr];
      if (clear) begin
        binValid <= '0;
      end else if (writeEn) begin
        binValid[writeAddr] <= 1'b1;
      end
    end
  end

  // Stale bins from an earlier image read as empty
  assign binReadData = readHit ? readCount : '0;

endmodule

// ==== cdfBuilder.sv ====
`timescale 1ns/1ps
//##########################################################
// CDF builder
// Sweeps the 256 bins in order, writes the running sum
// back in place and latches the smallest nonzero CDF
//##########################################################
module cdfBuilder (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             start,
  output logic [histEqPkg::PIXEL_BITS-1:0] binReadAddr,
  input  logic [histEqPkg::COUNT_BITS-1:0] binReadData,
  output logic                             binWrite,
  output logic [histEqPkg::PIXEL_BITS-1:0] binWriteAddr,
  output logic [histEqPkg::COUNT_BITS-1:0] binWriteData,
  output logic                             busy,
  output logic                             done,
  output logic                             cdfValid,
  output logic [histEqPkg::COUNT_BITS-1:0] cdfMin
);

  import histEqPkg::*;

  logic                  reading;
  logic [PIXEL_BITS-1:0] readBin;
  logic                  dataValid;
  logic [PIXEL_BITS-1:0] dataBin;
  logic                  dataLast;
  logic [COUNT_BITS-1:0] runningSum;
  logic [COUNT_BITS-1:0] nextSum;
  logic                  writeValid;
  logic [PIXEL_BITS-1:0] writeBin;

  assign nextSum = runningSum + binReadData;
  assign dataLast = dataValid && dataBin == PIXEL_BITS'(BIN_COUNT - 1);

  assign binReadAddr = readBin;
  // Sum register already holds the CDF of writeBin
  assign binWrite = writeValid;
  assign binWriteAddr = writeBin;
  assign binWriteData = runningSum;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      reading <= 1'b0;
      readBin <= '0;
      dataValid <= 1'b0;
      writeValid <= 1'b0;
      runningSum <= '0;
      done <= 1'b0;
      cdfValid <= 1'b0;
      cdfMin <= '0;
    end else begin
      dataValid <= reading;
      writeValid <= dataValid;
      done <= dataLast;
      if (start && !busy) begin
        busy <= 1'b1;
        reading <= 1'b1;
        readBin <= '0;
        runningSum <= '0;
        cdfValid <= 1'b0;
        cdfMin <= '0;
      end else begin
        if (reading) begin
          readBin <= readBin + 1'b1;
          if (readBin == PIXEL_BITS'(BIN_COUNT - 1)) begin
            reading <= 1'b0;
          end
        end
        if (dataValid) begin
          runningSum <= nextSum;
          // Sum never falls, so the first nonzero one is the minimum
          if (cdfMin == '0 && nextSum != '0) begin
            cdfMin <= nextSum;
          end
        end
        if (dataLast) begin
          cdfValid <= 1'b1;
        end
        if (done) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    dataBin <= readBin;
    writeBin <= dataBin;
  end

endmodule

// ==== pixelRemap.sv ====
`timescale 1ns/1ps
//##########################################################
// Pixel remap
// Reads the image again, maps each pixel through the CDF
// and packs 16 equalized pixels per output word
//##########################################################
module pixelRemap (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic [histEqPkg::COUNT_BITS-1:0] cdfMin,
  output logic [histEqPkg::ADDR_BITS-1:0]  imageReadAddr,
  input  logic [histEqPkg::WORD_BITS-1:0]  imageReadData,
  output logic [histEqPkg::PIXEL_BITS-1:0] binReadAddr,
  input  logic [histEqPkg::COUNT_BITS-1:0] binReadData,
  output logic                             outWrite,
  output logic [histEqPkg::ADDR_BITS-1:0]  outWriteAddr,
  output logic [histEqPkg::WORD_BITS-1:0]  outWriteData,
  output logic                             busy,
  output logic                             done
);

  import histEqPkg::*;

  logic                        issuing;
  logic [PIXEL_INDEX_BITS-1:0] issueIdx;
  logic                        fetchValid;
  logic [PIXEL_INDEX_BITS-1:0] fetchIdx;
  logic                        lookValid;
  logic [PIXEL_INDEX_BITS-1:0] lookIdx;
  logic                        wordDone;

  // Equalization arithmetic
  logic [COUNT_BITS-1:0]            span;
  logic [COUNT_BITS+PIXEL_BITS-1:0] scaled;
  logic [PIXEL_BITS-1:0]            eqValue;

  logic [WORD_BITS-1:0] packWord;
  logic [WORD_BITS-1:0] nextWord;

  assign imageReadAddr = ADDR_BITS'(issueIdx / PIXELS_PER_WORD);
  assign binReadAddr = imageReadData[(fetchIdx % PIXELS_PER_WORD) * PIXEL_BITS +: PIXEL_BITS];

  // (cdf - cdfMin) * 255 / (pixels - cdfMin)
  assign span = COUNT_BITS'(PIXEL_COUNT) - cdfMin;
  assign scaled = (COUNT_BITS + PIXEL_BITS)'(binReadData - cdfMin)
                * (COUNT_BITS + PIXEL_BITS)'(BIN_COUNT - 1);

  always_comb begin
    // Flat image leaves nothing to spread
    if (span == '0) begin
      eqValue = '0;
    end else begin
      eqValue = PIXEL_BITS'(scaled / (COUNT_BITS + PIXEL_BITS)'(span));
    end
    nextWord = packWord;
    nextWord[(lookIdx % PIXELS_PER_WORD) * PIXEL_BITS +: PIXEL_BITS] = eqValue;
  end

  assign wordDone = lookValid && (lookIdx % PIXELS_PER_WORD) == PIXELS_PER_WORD - 1;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      issuing <= 1'b0;
      issueIdx <= '0;
      fetchValid <= 1'b0;
      lookValid <= 1'b0;
      outWrite <= 1'b0;
      done <= 1'b0;
    end else begin
      fetchValid <= issuing;
      lookValid <= fetchValid;
      outWrite <= wordDone;
      done <= lookValid && lookIdx == PIXEL_INDEX_BITS'(PIXEL_COUNT - 1);
      if (start && !busy) begin
        busy <= 1'b1;
        issuing <= 1'b1;
        issueIdx <= '0;
      end else begin
        if (issuing) begin
          issueIdx <= issueIdx + 1'b1;
          if (issueIdx == PIXEL_INDEX_BITS'(PIXEL_COUNT - 1)) begin
            issuing <= 1'b0;
          end
        end
        if (done) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // Lane packing and word output
  always_ff @(posedge clock) begin
    fetchIdx <= issueIdx;
    lookIdx <= fetchIdx;
    if (lookValid) begin
      packWord <= nextWord;
    end
    if (wordDone) begin
      outWriteAddr <= ADDR_BITS'(lookIdx / PIXELS_PER_WORD);
      outWriteData <= nextWord;
    end
  end

endmodule

// ==== histEqTop.sv ====
`timescale 1ns/1ps
//##########################################################
// Histogram equalizer top level
// Chains the counting, CDF and remap engines through
// start and done pulses around one bin scratchpad
//##########################################################
module histEqTop (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             start,
  output logic [histEqPkg::ADDR_BITS-1:0]  imageReadAddr,
  input  logic [histEqPkg::WORD_BITS-1:0]  imageReadData,
  output logic                             outWrite,
  output logic [histEqPkg::ADDR_BITS-1:0]  outWriteAddr,
  output logic [histEqPkg::WORD_BITS-1:0]  outWriteData,
  output logic                             done,
  output logic                             cdfValid,
  output logic [histEqPkg::COUNT_BITS-1:0] cdfMin
);

  import histEqPkg::*;

  // Engine handshakes
  logic acceptStart;
  logic histBusy;
  logic histDone;
  logic cdfBusy;
  logic cdfDone;
  logic remapBusy;

  // Image address of each reader
  logic [ADDR_BITS-1:0] histImageAddr;
  logic [ADDR_BITS-1:0] remapImageAddr;

  // Scratchpad ports
  logic [PIXEL_BITS-1:0] histBinReadAddr;
  logic                  histBinWrite;
  logic [PIXEL_BITS-1:0] histBinWriteAddr;
  logic [COUNT_BITS-1:0] histBinWriteData;
  logic [PIXEL_BITS-1:0] cdfBinReadAddr;
  logic                  cdfBinWrite;
  logic [PIXEL_BITS-1:0] cdfBinWriteAddr;
  logic [COUNT_BITS-1:0] cdfBinWriteData;
  logic [PIXEL_BITS-1:0] remapBinReadAddr;
  logic [COUNT_BITS-1:0] binReadData;

  // A start during any pass is dropped, so the clear never hits live bins
  assign acceptStart = start && !(histBusy || cdfBusy || remapBusy);

  histCounter counter (
    .clock         (clock),
    .rst_n         (rst_n),
    .start         (acceptStart),
    .imageReadData (imageReadData),
    .imageReadAddr (histImageAddr),
    .binReadAddr   (histBinReadAddr),
    .binReadData   (binReadData),
    .binWrite      (histBinWrite),
    .binWriteAddr  (histBinWriteAddr),
    .binWriteData  (histBinWriteData),
    .busy          (histBusy),
    .done          (histDone)
  );

  binScratchpad scratchpad (
    .clock            (clock),
    .rst_n            (rst_n),
    .clear            (acceptStart),
    .histBinReadAddr  (histBinReadAddr),
    .histBinWrite     (histBinWrite),
    .histBinWriteAddr (histBinWriteAddr),
    .histBinWriteData (histBinWriteData),
    .cdfBinReadAddr   (cdfBinReadAddr),
    .cdfBinWrite      (cdfBinWrite),
    .cdfBinWriteAddr  (cdfBinWriteAddr),
    .cdfBinWriteData  (cdfBinWriteData),
    .remapBinReadAddr (remapBinReadAddr),
    .histBusy         (histBusy),
    .cdfBusy          (cdfBusy),
    .remapBusy        (remapBusy),
    .histReadAddr     (histImageAddr),
    .remapReadAddr    (remapImageAddr),
    .imageReadAddr    (imageReadAddr),
    .binReadData      (binReadData)
  );

  cdfBuilder cdf (
    .clock        (clock),
    .rst_n        (rst_n),
    .start        (histDone),
    .binReadAddr  (cdfBinReadAddr),
    .binReadData  (binReadData),
    .binWrite     (cdfBinWrite),
    .binWriteAddr (cdfBinWriteAddr),
    .binWriteData (cdfBinWriteData),
    .busy         (cdfBusy),
    .done         (cdfDone),
    .cdfValid     (cdfValid),
    .cdfMin       (cdfMin)
  );

  pixelRemap remap (
    .clock         (clock),
    .rst_n         (rst_n),
    .start         (cdfDone),
    .cdfMin        (cdfMin),
    .imageReadAddr (remapImageAddr),
    .imageReadData (imageReadData),
    .binReadAddr   (remapBinReadAddr),
    .binReadData   (binReadData),
    .outWrite      (outWrite),
    .outWriteAddr  (outWriteAddr),
    .outWriteData  (outWriteData),
    .busy          (remapBusy),
    .done          (done)
  );

endmodule

// ==== histEq_asserts.sv ====
`timescale 1ns/1ps
//##########################################################
// Histogram equalizer handshake checks
// Bound to the top level: single-cycle done, one busy
// engine at a time, output writes only during remap
//##########################################################
module histEqChecks (
  input logic clock,
  input logic rst_n,
  input logic done,
  input logic outWrite,
  input logic histBusy,
  input logic cdfBusy,
  input logic remapBusy
);

  doneOneCycle: assert property (@(posedge clock) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high longer than one cycle");

  // Scratchpad has one owner
  singleOwner: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0({histBusy, cdfBusy, remapBusy}))
    else $error("more than one engine busy");

  writeInRemap: assert property (@(posedge clock) disable iff (!rst_n) outWrite |-> remapBusy)
    else $error("outWrite high while remap engine idle");

endmodule

bind histEqTop histEqChecks checks (
  .clock     (clock),
  .rst_n     (rst_n),
  .done      (done),
  .outWrite  (outWrite),
  .histBusy  (histBusy),
  .cdfBusy   (cdfBusy),
  .remapBusy (remapBusy)
);

// ==== tb_histEq.sv ====
`timescale 1ns/1ps
//##########################################################
// Histogram equalizer testbench
// Image and output memory models, a reference equalizer
// and a compare process over six scenarios
//##########################################################
module tb_histEq;

  import histEqPkg::*;

  localparam int DONE_TIMEOUT = 2000;
  localparam int ACK_TIMEOUT = 10;
  localparam int QUIET_CYCLES = 500;
  localparam int WORD_INDEX_BITS = $clog2(IMAGE_WORDS);

  logic                  clock;
  logic                  rst_n;
  logic                  start;
  logic [ADDR_BITS-1:0]  imageReadAddr;
  logic [WORD_BITS-1:0]  imageReadData = '0;
  logic                  outWrite;
  logic [ADDR_BITS-1:0]  outWriteAddr;
  logic [WORD_BITS-1:0]  outWriteData;
  logic                  done;
  logic                  cdfValid;
  logic [COUNT_BITS-1:0] cdfMin;

  // Memory models and expected results
  logic [WORD_BITS-1:0]  imageMem [IMAGE_WORDS];
  logic [WORD_BITS-1:0]  outMem [IMAGE_WORDS];
  logic [WORD_BITS-1:0]  expWords [IMAGE_WORDS];
  logic [COUNT_BITS-1:0] expMin;
  logic                  outClear;

  // Run bookkeeping
  int    writeCount = 0;
  int    doneCount = 0;
  int    writeBase = 0;
  int    checkReq = 0;
  int    checkAck = 0;
  bit    checkWords = 1'b0;
  int    stimErrors = 0;
  int    compareErrors = 0;
  int    stimBase = 0;
  int    compareBase = 0;
  int    testsRun = 0;
  int    testsFailed = 0;
  bit    aborted = 1'b0;
  string testName = "";

  histEqTop UUT (
    .clock         (clock),
    .rst_n         (rst_n),
    .start         (start),
    .imageReadAddr (imageReadAddr),
    .imageReadData (imageReadData),
    .outWrite      (outWrite),
    .outWriteAddr  (outWriteAddr),
    .outWriteData  (outWriteData),
    .done          (done),
    .cdfValid      (cdfValid),
    .cdfMin        (cdfMin)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Image memory answers one cycle after the address
  always @(posedge clock) begin
    imageReadData <= imageMem[imageReadAddr[WORD_INDEX_BITS-1:0]];
  end

  // Output memory refilled with an address pattern before each test
  always @(posedge clock) begin
    if (outClear) begin
      for (int w = 0; w < IMAGE_WORDS; w++) begin
        outMem[w] <= {4{32'hbad00000 + w}};
      end
    end else if (outWrite) begin
      outMem[outWriteAddr[WORD_INDEX_BITS-1:0]] <= outWriteData;
      writeCount <= writeCount + 1;
    end
    if (done) begin
      doneCount <= doneCount + 1;
    end
  end

  function automatic logic [PIXEL_BITS-1:0] pixelAt(input int i);
    return imageMem[i / PIXELS_PER_WORD][(i % PIXELS_PER_WORD) * PIXEL_BITS +: PIXEL_BITS];
  endfunction

  // Histogram, CDF and the equalization rule
  function automatic void buildReference();
    int hist [BIN_COUNT];
    int cdf [BIN_COUNT];
    int running;
    int minCdf;
    int span;
    for (int b = 0; b < BIN_COUNT; b++) begin
      hist[b] = 0;
    end
    for (int i = 0; i < PIXEL_COUNT; i++) begin
      hist[pixelAt(i)]++;
    end
    running = 0;
    minCdf = 0;
    for (int b = 0; b < BIN_COUNT; b++) begin
      running += hist[b];
      cdf[b] = running;
      if (minCdf == 0 && running != 0) begin
        minCdf = running;
      end
    end
    span = PIXEL_COUNT - minCdf;
    for (int i = 0; i < PIXEL_COUNT; i++) begin
      expWords[i / PIXELS_PER_WORD][(i % PIXELS_PER_WORD) * PIXEL_BITS +: PIXEL_BITS] =
        (span == 0) ? 8'd0 : PIXEL_BITS'((cdf[pixelAt(i)] - minCdf) * 255 / span);
    end
    expMin = COUNT_BITS'(minCdf);
  endfunction

  // Runs of one value beside alternating values
  function automatic logic [PIXEL_BITS-1:0] runPixel(input int i);
    if (i < 16) begin
      return 8'h11;
    end else if (i < 32) begin
      return (i % 2 == 0) ? 8'h22 : 8'h33;
    end else if (i < 40) begin
      return 8'h44;
    end else if (i < 48) begin
      return (i % 2 == 0) ? 8'h11 : 8'h44;
    end else begin
      return (i % 4 < 2) ? 8'h55 : 8'h22;
    end
  endfunction

  // Compare process prints one verdict line per request
  always @(negedge clock) begin
    if (checkAck != checkReq) begin
      if (checkWords) begin
        for (int w = 0; w < IMAGE_WORDS; w++) begin
          if (outMem[w] !== expWords[w]) begin
            $display("Fail at %0t: outWriteData word %0d expected %h got %h",
                     $time, w, expWords[w], outMem[w]);
            compareErrors++;
          end
        end
        if (cdfMin !== expMin) begin
          $display("Fail at %0t: cdfMin expected %0d got %0d", $time, expMin, cdfMin);
          compareErrors++;
        end
        if (cdfValid !== 1'b1) begin
          $display("Fail at %0t: cdfValid expected 1 got %b", $time, cdfValid);
          compareErrors++;
        end
        if (writeCount - writeBase != IMAGE_WORDS) begin
          $display("Fail at %0t: outWrite count expected %0d got %0d",
                   $time, IMAGE_WORDS, writeCount - writeBase);
          compareErrors++;
        end
      end
      testsRun++;
      if (compareErrors != compareBase || stimErrors != stimBase) begin
        testsFailed++;
        $display("Test %0d %s: failed", testsRun, testName);
      end else begin
        $display("Test %0d %s: passed", testsRun, testName);
      end
      compareBase = compareErrors;
      stimBase = stimErrors;
      checkAck = checkReq;
    end
  end

  task automatic pulseStart();
    start = 1'b1;
    @(negedge clock);
    start = 1'b0;
  endtask

  task automatic waitForDone(output bit seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(negedge clock);
      seen = done;
      cycles++;
    end
    if (!seen) begin
      $display("Timeout: no done within %0d cycles in test %s", DONE_TIMEOUT, testName);
      stimErrors++;
      aborted = 1'b1;
    end
  endtask

  // Hand the finished test to the compare process
  task automatic requestCheck(input bit withWords);
    int cycles;
    checkWords = withWords;
    checkReq++;
    cycles = 0;
    while (checkAck != checkReq && cycles < ACK_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (checkAck != checkReq) begin
      $display("Compare process gave no verdict for test %s", testName);
      aborted = 1'b1;
    end
  endtask

  task automatic prepareTest(input string name);
    testName = name;
    buildReference();
    outClear = 1'b1;
    @(negedge clock);
    outClear = 1'b0;
    writeBase = writeCount;
  endtask

  task automatic runImage(input string name);
    bit seen;
    if (!aborted) begin
      prepareTest(name);
      pulseStart();
      waitForDone(seen);
      // Last word lands on the next rising edge
      @(negedge clock);
      requestCheck(seen);
    end
  endtask

  // Extra starts during the counting and CDF passes must be dropped
  task automatic runWithExtraStarts();
    bit seen;
    int doneBase;
    int quiet;
    if (!aborted) begin
      prepareTest("ignored start");
      doneBase = doneCount;
      pulseStart();
      repeat (30) @(negedge clock);
      pulseStart();
      repeat (120) @(negedge clock);
      pulseStart();
      waitForDone(seen);
      quiet = 0;
      while (quiet < QUIET_CYCLES) begin
        @(negedge clock);
        quiet++;
      end
      if (doneCount - doneBase != 1) begin
        $display("Fail at %0t: done pulse count expected 1 got %0d",
                 $time, doneCount - doneBase);
        stimErrors++;
      end
      requestCheck(seen);
    end
  endtask

  task automatic fillRandom();
    for (int w = 0; w < IMAGE_WORDS; w++) begin
      imageMem[w] = {$urandom, $urandom, $urandom, $urandom};
    end
  endtask

  initial begin
    logic [PIXEL_BITS-1:0] value;
    void'($urandom(32'hc5b91c26));
    rst_n = 1'b0;
    start = 1'b0;
    outClear = 1'b0;
    for (int w = 0; w < IMAGE_WORDS; w++) begin
      imageMem[w] = '0;
    end
    repeat (3) @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);

    testName = "reset state";
    if (done !== 1'b0 || cdfValid !== 1'b0 || outWrite !== 1'b0) begin
      $display("Fail at %0t: done/cdfValid/outWrite expected 000 got %b%b%b",
               $time, done, cdfValid, outWrite);
      stimErrors++;
    end
    if (cdfMin !== '0) begin
      $display("Fail at %0t: cdfMin expected 0 got %0d", $time, cdfMin);
      stimErrors++;
    end
    requestCheck(1'b0);

    fillRandom();
    runImage("random image");

    value = PIXEL_BITS'($urandom);
    for (int w = 0; w < IMAGE_WORDS; w++) begin
      imageMem[w] = {PIXELS_PER_WORD{value}};
    end
    runImage("constant image");

    for (int i = 0; i < PIXEL_COUNT; i++) begin
      imageMem[i / PIXELS_PER_WORD][(i % PIXELS_PER_WORD) * PIXEL_BITS +: PIXEL_BITS] =
        runPixel(i);
    end
    runImage("repeat runs");

    fillRandom();
    runImage("back to back first");
    fillRandom();
    runImage("back to back second");

    fillRandom();
    runWithExtraStarts();

    $display("Tests run %0d, passed %0d, failed %0d",
             testsRun, testsRun - testsFailed, testsFailed);
    if (testsFailed != 0 || aborted) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
histEqPkg.sv
histCounter.sv
binScratchpad.sv
cdfBuilder.sv
pixelRemap.sv
histEqTop.sv
histEq_asserts.sv
tb_histEq.sv

// ==== Makefile ====
# Verilator build and run of the histogram equalizer testbench

VERILATOR ?= verilator
TOP       ?= tb_histEq
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_TEXT ?= Testbench failed
PASS_TEXT ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
